//--- ecc_rnd_subsystem.f
source/ecc_rnd_cfg_pkg.sv
source/ecc_rnd_mode_pkg.sv
source/drbg_if.sv
source/lfsr_mask_gen.sv
source/mix_drbg_core.sv
source/drbg_sequencer.sv
source/ecc_rnd_subsystem.sv
test/ecc_rnd_subsystem_properties.sv
test/ecc_rnd_subsystem_tb.sv

//--- test/ecc_rnd_subsystem_tb.sv
// random value subsystem testbench
`default_nettype none

module ecc_rnd_subsystem_tb
    import ecc_rnd_cfg_pkg::*;
    import ecc_rnd_mode_pkg::*;
();

    localparam int REG_SIZE = 64;
    // just above half the range, so the subtraction path is common
    localparam logic [REG_SIZE-1:0] GROUP_ORDER = 64'h8000_0000_0000_0b3d;
    localparam int N_REQUESTS   = 13;
    localparam int RESET_CYCLES = 4;
    // five commands per request at most
    localparam int WATCHDOG_CYCLES =
        N_REQUESTS * 5 * (MIX_ROUNDS + 3) + RESET_CYCLES + 20;

    typedef logic [REG_SIZE-1:0] word_t;

    typedef struct packed {
        word_t      lambda;
        word_t      scalar_rnd;
        word_t      masking_rnd;
        word_t      drbg;
        logic [7:0] reductions;
    } rnd_expect_t;

    logic      clk = 1'b0;
    logic      reset_n;
    logic      zeroize;
    logic      en;
    rnd_mode_e mode;
    word_t     keygen_seed;
    word_t     keygen_nonce;
    word_t     priv_key;
    word_t     hashed_msg;
    word_t     iv;
    logic      ready;
    word_t     lambda;
    word_t     scalar_rnd;
    word_t     masking_rnd;
    word_t     drbg;

    int          error_count    = 0;
    int          check_count    = 0;
    int          test_count     = 0;
    int          reqs_issued    = 0;
    int          reqs_checked   = 0;
    int          reduction_hits = 0;
    logic [31:0] lcg_state      = 32'h654a;

    ecc_rnd_subsystem #(
        .REG_SIZE    (REG_SIZE),
        .GROUP_ORDER (GROUP_ORDER)
    ) i_ecc_rnd_subsystem (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize      (zeroize),
        .en           (en),
        .mode         (mode),
        .keygen_seed  (keygen_seed),
        .keygen_nonce (keygen_nonce),
        .priv_key     (priv_key),
        .hashed_msg   (hashed_msg),
        .iv           (iv),
        .ready        (ready),
        .lambda       (lambda),
        .scalar_rnd   (scalar_rnd),
        .masking_rnd  (masking_rnd),
        .drbg         (drbg)
    );

    always #2 clk = ~clk;

    // ----------------------------------------------------------
    // stimulus source
    // ----------------------------------------------------------
    function automatic logic [31:0] lcg_step();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t random_word();
        word_t w;
        w[63:32] = lcg_step();
        w[31:0]  = lcg_step();
        return w;
    endfunction

    // ----------------------------------------------------------
    // reference model
    // ----------------------------------------------------------
    function automatic word_t rotate_left(input word_t x, input int n);
        return (x << n) | (x >> (REG_SIZE - n));
    endfunction

    // xor key, add rotated copy, xor-shift, MIX_ROUNDS times
    function automatic word_t run_rounds(input word_t v, input word_t k);
        word_t t;
        t = v;
        for (int r = 0; r < MIX_ROUNDS; r++)
        begin
            t = t ^ k;
            t = t + rotate_left(t, MIX_ROT_A);
            t = t ^ (t >> MIX_ROT_B);
        end
        return t;
    endfunction

    function automatic word_t reduce_order(input word_t v);
        return (v >= GROUP_ORDER) ? v - GROUP_ORDER : v;
    endfunction

    // full command chain of one request, untouched outputs from prev
    function automatic rnd_expect_t ref_request(
        input rnd_mode_e   m,
        input logic [15:0] count,
        input word_t       seed,
        input word_t       seed_nonce,
        input word_t       key,
        input word_t       msg,
        input word_t       iv_in,
        input rnd_expect_t prev
    );
        word_t       k;
        word_t       v;
        word_t       nonce;
        rnd_expect_t e;
        e            = prev;
        e.reductions = '0;
        nonce        = {(REG_SIZE / 16){count}};
        // reseed value, only feeds the mask
        k = iv_in ^ rotate_left(nonce, MIX_ROT_A);
        v = run_rounds(nonce, k);
        v = run_rounds(v, k);
        e.lambda     = reduce_order(v);
        e.reductions = e.reductions + (v >= GROUP_ORDER);
        v = run_rounds(v, k);
        e.scalar_rnd = reduce_order(v);
        e.reductions = e.reductions + (v >= GROUP_ORDER);
        if (m == MODE_SIGN)
        begin
            v = run_rounds(v, k);
            e.masking_rnd = reduce_order(v);
            e.reductions  = e.reductions + (v >= GROUP_ORDER);
            k = key ^ rotate_left(msg, MIX_ROT_A);
            v = run_rounds(msg, k);
            e.drbg       = reduce_order(v);
            e.reductions = e.reductions + (v >= GROUP_ORDER);
        end
        else if (m == MODE_KEYGEN)
        begin
            k = seed ^ rotate_left(seed_nonce, MIX_ROT_A);
            v = run_rounds(seed_nonce, k);
            e.drbg       = reduce_order(v);
            e.reductions = e.reductions + (v >= GROUP_ORDER);
        end
        return e;
    endfunction

    // ----------------------------------------------------------
    // checks
    // ----------------------------------------------------------
    task automatic check_word(input string name, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_mode(input string name, input rnd_mode_e got, input rnd_mode_e exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_below(input string name, input word_t got);
        check_count++;
        if (got >= GROUP_ORDER)
        begin
            error_count++;
            $display("%s value %h is not below the group order", name, got);
        end
    endtask

    // ----------------------------------------------------------
    // compare process
    // ----------------------------------------------------------
    // picks up each accepted en, waits for ready, checks outputs
    initial
    begin : compare_results
        rnd_mode_e   req_mode;
        rnd_mode_e   path_mode;
        word_t       req_seed;
        word_t       req_nonce;
        word_t       req_key;
        word_t       req_msg;
        word_t       req_iv;
        logic [15:0] model_count;
        logic        aborted;
        rnd_expect_t expect_q;
        rnd_expect_t expect_n;
        model_count = '0;
        expect_q    = '0;
        forever
        begin
            @(posedge clk);
            if (reset_n && !zeroize && en && ready)
            begin
                req_mode    = mode;
                req_seed    = keygen_seed;
                req_nonce   = keygen_nonce;
                req_key     = priv_key;
                req_msg     = hashed_msg;
                req_iv      = iv;
                model_count = model_count + 1'b1;
                aborted     = 1'b0;
                // branch taken by the sequencer, shared secret unless seen otherwise
                path_mode   = MODE_DH;
                do
                begin
                    @(negedge clk);
                    if (zeroize)
                        aborted = 1'b1;
                    if (i_ecc_rnd_subsystem.i_drbg_sequencer.state == ST_MASKING)
                        path_mode = MODE_SIGN;
                    else if (i_ecc_rnd_subsystem.i_drbg_sequencer.state == ST_KEYGEN)
                        path_mode = MODE_KEYGEN;
                end
                while (!ready);
                if (aborted)
                begin
                    // zeroize clears outputs and the request count
                    model_count = '0;
                    expect_q    = '0;
                    check_word("lambda", lambda, '0);
                    check_word("scalar_rnd", scalar_rnd, '0);
                    check_word("masking_rnd", masking_rnd, '0);
                    check_word("drbg", drbg, '0);
                end
                else
                begin
                    expect_n = ref_request(req_mode, model_count, req_seed, req_nonce,
                                           req_key, req_msg, req_iv, expect_q);
                    reduction_hits += expect_n.reductions;
                    check_word("lambda", lambda, expect_n.lambda);
                    check_word("scalar_rnd", scalar_rnd, expect_n.scalar_rnd);
                    check_word("masking_rnd", masking_rnd, expect_n.masking_rnd);
                    check_word("drbg", drbg, expect_n.drbg);
                    check_below("lambda", lambda);
                    check_below("scalar_rnd", scalar_rnd);
                    check_below("masking_rnd", masking_rnd);
                    check_below("drbg", drbg);
                    // mode the sequencer actually branched on
                    check_mode("mode", path_mode, req_mode);
                    expect_q = expect_n;
                end
                reqs_checked++;
            end
        end
    end

    // ----------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------
    // inputs stay put until the next request
    task automatic run_request(
        input rnd_mode_e m,
        input word_t     seed,
        input word_t     seed_nonce,
        input word_t     key,
        input word_t     msg,
        input word_t     iv_in
    );
        @(posedge clk);
        mode         <= m;
        keygen_seed  <= seed;
        keygen_nonce <= seed_nonce;
        priv_key     <= key;
        hashed_msg   <= msg;
        iv           <= iv_in;
        en           <= 1'b1;
        reqs_issued++;
        @(posedge clk);
        en <= 1'b0;
        wait (reqs_checked == reqs_issued);
    endtask

    task automatic run_random(input rnd_mode_e m);
        run_request(m, random_word(), random_word(), random_word(),
                    random_word(), random_word());
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_count++;
        $display("test %0d %-18s %s", test_count, name,
                 (error_count == errs_before) ? "ok" : "errors");
    endtask

    initial
    begin : stimulus
        int         errs;
        word_t      first_lambda;
        word_t      same[5];
        logic [1:0] sel;
        reset_n      <= 1'b0;
        zeroize      <= 1'b0;
        en           <= 1'b0;
        mode         <= MODE_KEYGEN;
        keygen_seed  <= '0;
        keygen_nonce <= '0;
        priv_key     <= '0;
        hashed_msg   <= '0;
        iv           <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;

        // idle state after reset
        errs = error_count;
        @(negedge clk);
        check_count++;
        if (ready !== 1'b1)
        begin
            error_count++;
            $display("ready is not high after reset");
        end
        check_word("lambda", lambda, '0);
        check_word("scalar_rnd", scalar_rnd, '0);
        check_word("masking_rnd", masking_rnd, '0);
        check_word("drbg", drbg, '0);
        end_test("reset", errs);

        errs = error_count;
        run_random(MODE_KEYGEN);
        end_test("keygen", errs);

        errs = error_count;
        run_random(MODE_SIGN);
        end_test("sign", errs);

        errs = error_count;
        run_random(MODE_DH);
        end_test("shared secret", errs);

        // identical inputs, only the request count differs
        errs = error_count;
        for (int i = 0; i < 5; i++)
            same[i] = random_word();
        run_request(MODE_KEYGEN, same[0], same[1], same[2], same[3], same[4]);
        first_lambda = lambda;
        run_request(MODE_KEYGEN, same[0], same[1], same[2], same[3], same[4]);
        check_count++;
        if (lambda == first_lambda)
        begin
            error_count++;
            $display("identical requests gave the same lambda %h", lambda);
        end
        end_test("back to back", errs);

        // random modes, results against the group order
        errs = error_count;
        for (int i = 0; i < 6; i++)
        begin
            sel = 2'(lcg_step() % 32'd3);
            run_random(rnd_mode_e'(sel));
        end
        check_count++;
        if (reduction_hits == 0)
        begin
            error_count++;
            $display("no result needed the group order subtraction");
        end
        end_test("group order", errs);

        // zeroize partway through a sign request
        errs = error_count;
        @(posedge clk);
        mode <= MODE_SIGN;
        en   <= 1'b1;
        reqs_issued++;
        @(posedge clk);
        en <= 1'b0;
        repeat (3 * (MIX_ROUNDS + 1)) @(posedge clk);
        zeroize <= 1'b1;
        @(posedge clk);
        zeroize <= 1'b0;
        wait (reqs_checked == reqs_issued);
        // counts again from one
        run_random(MODE_KEYGEN);
        end_test("zeroize", errs);

        $display("summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    // ----------------------------------------------------------
    // watchdog
    // ----------------------------------------------------------
    initial
    begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run still going after %0d cycles", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/ecc_rnd_subsystem_properties.sv
// command bus assertions
`default_nettype none

module ecc_rnd_subsystem_properties
    import ecc_rnd_cfg_pkg::*;
(
    input logic      clk,
    input logic      reset_n,
    input logic      zeroize,
    input drbg_cmd_e cmd,
    input logic      ready,
    input logic      valid
);

    // ----------------------------------------------------------
    // core timing
    // ----------------------------------------------------------
    // quiet for MIX_ROUNDS cycles, then the valid pulse
    property p_cmd_to_valid;
        @(posedge clk) disable iff (!reset_n || zeroize)
        (cmd != CMD_NONE) |=> (!valid) [*MIX_ROUNDS] ##1 valid;
    endproperty

    // commands only into an idle core
    property p_cmd_when_ready;
        @(posedge clk) disable iff (!reset_n || zeroize)
        (cmd != CMD_NONE) |-> ready;
    endproperty

    // idle right out of reset
    property p_ready_after_reset;
        @(posedge clk) $rose(reset_n) |-> ready;
    endproperty

    a_cmd_to_valid: assert property (p_cmd_to_valid)
        else $error("valid not seen %0d cycles after cmd", MIX_ROUNDS + 1);
    a_cmd_when_ready: assert property (p_cmd_when_ready)
        else $error("cmd issued while ready was low");
    a_ready_after_reset: assert property (p_ready_after_reset)
        else $error("ready low after reset release");

endmodule

// full bus view inside the core
bind mix_drbg_core ecc_rnd_subsystem_properties i_core_checks (
    .clk     (clk),
    .reset_n (reset_n),
    .zeroize (zeroize),
    .cmd     (drbg.cmd),
    .ready   (drbg.ready),
    .valid   (drbg.valid)
);

// sequencer side of the same bus
bind drbg_sequencer ecc_rnd_subsystem_properties i_seq_checks (
    .clk     (clk),
    .reset_n (reset_n),
    .zeroize (zeroize),
    .cmd     (drbg_bus.cmd),
    .ready   (drbg_bus.ready),
    .valid   (drbg_bus.valid)
);

`default_nettype wire

//--- source/ecc_rnd_subsystem.sv
// elliptic-curve random value subsystem
`default_nettype none

module ecc_rnd_subsystem
    import ecc_rnd_cfg_pkg::*;
    import ecc_rnd_mode_pkg::*;
#(
    parameter int                  REG_SIZE       = 64,
    // largest 64-bit prime by default
    parameter logic [REG_SIZE-1:0] GROUP_ORDER    = 64'hffff_ffff_ffff_ffc5,
    parameter logic [REG_SIZE-1:0] MASK_INIT_SEED = DEFAULT_MASK_SEED[REG_SIZE-1:0]
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize,
    input  logic                en,
    input  rnd_mode_e           mode,
    input  logic [REG_SIZE-1:0] keygen_seed,
    input  logic [REG_SIZE-1:0] keygen_nonce,
    input  logic [REG_SIZE-1:0] priv_key,
    input  logic [REG_SIZE-1:0] hashed_msg,
    input  logic [REG_SIZE-1:0] iv,
    output logic                ready,
    output logic [REG_SIZE-1:0] lambda,
    output logic [REG_SIZE-1:0] scalar_rnd,
    output logic [REG_SIZE-1:0] masking_rnd,
    output logic [REG_SIZE-1:0] drbg
);

    // ------------------------------------------------------------
    // internal wiring
    // ------------------------------------------------------------
    drbg_if #(.REG_SIZE(REG_SIZE)) drbg_bus ();

    logic [REG_SIZE-1:0] mask;
    logic                reseed;
    logic [REG_SIZE-1:0] reseed_value;

    drbg_sequencer #(
        .REG_SIZE (REG_SIZE)
    ) i_drbg_sequencer (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize      (zeroize),
        .en           (en),
        .mode         (mode),
        .keygen_seed  (keygen_seed),
        .keygen_nonce (keygen_nonce),
        .priv_key     (priv_key),
        .hashed_msg   (hashed_msg),
        .iv           (iv),
        .drbg_bus     (drbg_bus.sequencer),
        .reseed       (reseed),
        .reseed_value (reseed_value),
        .ready        (ready),
        .lambda       (lambda),
        .scalar_rnd   (scalar_rnd),
        .masking_rnd  (masking_rnd),
        .drbg         (drbg)
    );

    // core and mask generator side by side
    mix_drbg_core #(
        .REG_SIZE    (REG_SIZE),
        .GROUP_ORDER (GROUP_ORDER)
    ) i_mix_drbg_core (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .drbg    (drbg_bus.core),
        .mask    (mask)
    );

    lfsr_mask_gen #(
        .REG_SIZE       (REG_SIZE),
        .MASK_INIT_SEED (MASK_INIT_SEED)
    ) i_lfsr_mask_gen (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize      (zeroize),
        .reseed       (reseed),
        .reseed_value (reseed_value),
        .mask         (mask)
    );

endmodule

`default_nettype wire

//--- source/drbg_sequencer.sv
// random value request sequencer
`default_nettype none

module drbg_sequencer
    import ecc_rnd_cfg_pkg::*;
    import ecc_rnd_mode_pkg::*;
#(
    parameter int REG_SIZE = 64
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize,
    input  logic                en,
    input  rnd_mode_e           mode,
    input  logic [REG_SIZE-1:0] keygen_seed,
    input  logic [REG_SIZE-1:0] keygen_nonce,
    input  logic [REG_SIZE-1:0] priv_key,
    input  logic [REG_SIZE-1:0] hashed_msg,
    input  logic [REG_SIZE-1:0] iv,
    drbg_if.sequencer           drbg_bus,
    output logic                reseed,
    output logic [REG_SIZE-1:0] reseed_value,
    output logic                ready,
    output logic [REG_SIZE-1:0] lambda,
    output logic [REG_SIZE-1:0] scalar_rnd,
    output logic [REG_SIZE-1:0] masking_rnd,
    output logic [REG_SIZE-1:0] drbg
);

    // request counter, replicated into the nonce
    localparam int CNT_W      = 16;
    localparam int NONCE_REPS = REG_SIZE / CNT_W;

    seq_state_e          state;
    seq_state_e          state_next;
    seq_state_e          state_last;

    logic [CNT_W-1:0]    req_cnt;
    logic [REG_SIZE-1:0] counter_nonce;
    logic                en_accept;
    logic                entry;

    drbg_cmd_e           cmd;
    logic [REG_SIZE-1:0] entropy;
    logic [REG_SIZE-1:0] nonce;

    assign en_accept     = en && (state == ST_IDLE) && drbg_bus.ready;
    // first cycle in a state
    assign entry         = (state != state_last);
    assign counter_nonce = {NONCE_REPS{req_cnt}};

    // ------------------------------------------------------------
    // command issue
    // ------------------------------------------------------------
    // one strobe on entry to a working state
    always_comb
    begin
        cmd = CMD_NONE;
        if (entry)
        begin
            case (state)
                ST_RESEED:  cmd = CMD_INIT;
                ST_LAMBDA:  cmd = CMD_NEXT;
                ST_SCALAR:  cmd = CMD_NEXT;
                ST_MASKING: cmd = CMD_NEXT;
                ST_KEYGEN:  cmd = CMD_INIT;
                ST_SIGN:    cmd = CMD_INIT;
                default:    cmd = CMD_NONE;
            endcase
        end
    end

    // iv path for the masking chain, user data for the final init
    always_comb
    begin
        case (state)
            ST_KEYGEN:
            begin
                entropy = keygen_seed;
                nonce   = keygen_nonce;
            end
            ST_SIGN:
            begin
                entropy = priv_key;
                nonce   = hashed_msg;
            end
            default:
            begin
                entropy = iv;
                nonce   = counter_nonce;
            end
        endcase
    end

    assign drbg_bus.cmd     = cmd;
    assign drbg_bus.entropy = entropy;
    assign drbg_bus.nonce   = nonce;

    // ------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------
    always_comb
    begin
        state_next = state;
        case (state)
            ST_IDLE:    if (en_accept)      state_next = ST_RESEED;
            ST_RESEED:  if (drbg_bus.valid) state_next = ST_LAMBDA;
            ST_LAMBDA:  if (drbg_bus.valid) state_next = ST_SCALAR;
            ST_SCALAR:  if (drbg_bus.valid) state_next = ST_BRANCH;
            ST_BRANCH:
            begin
                if (mode == MODE_SIGN)
                    state_next = ST_MASKING;
                else if (mode == MODE_KEYGEN)
                    state_next = ST_KEYGEN;
                else
                    state_next = ST_DONE;
            end
            ST_MASKING: if (drbg_bus.valid) state_next = ST_SIGN;
            ST_KEYGEN:  if (drbg_bus.valid) state_next = ST_DONE;
            ST_SIGN:    if (drbg_bus.valid) state_next = ST_DONE;
            default:    state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            state      <= ST_IDLE;
            state_last <= ST_IDLE;
            req_cnt    <= '0;
        end
        else if (zeroize)
        begin
            state      <= ST_IDLE;
            state_last <= ST_IDLE;
            req_cnt    <= '0;
        end
        else
        begin
            state      <= state_next;
            state_last <= state;
            // counts requests, not cycles
            if (en_accept)
            begin
                req_cnt <= req_cnt + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // result capture
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            lambda      <= '0;
            scalar_rnd  <= '0;
            masking_rnd <= '0;
            drbg        <= '0;
        end
        else if (zeroize)
        begin
            lambda      <= '0;
            scalar_rnd  <= '0;
            masking_rnd <= '0;
            drbg        <= '0;
        end
        else if (drbg_bus.valid)
        begin
            case (state)
                ST_LAMBDA:  lambda      <= drbg_bus.result;
                ST_SCALAR:  scalar_rnd  <= drbg_bus.result;
                ST_MASKING: masking_rnd <= drbg_bus.result;
                ST_KEYGEN:  drbg        <= drbg_bus.result;
                ST_SIGN:    drbg        <= drbg_bus.result;
                default:    ;
            endcase
        end
    end

    // reseed result goes straight to the mask generator
    assign reseed       = drbg_bus.valid && (state == ST_RESEED);
    assign reseed_value = drbg_bus.result;

    assign ready = (state == ST_IDLE);

endmodule

`default_nettype wire

//--- source/mix_drbg_core.sv
// iterated mixing generator core
`default_nettype none

module mix_drbg_core
    import ecc_rnd_cfg_pkg::*;
#(
    parameter int                  REG_SIZE    = 64,
    parameter logic [REG_SIZE-1:0] GROUP_ORDER = 64'hffff_ffff_ffff_ffc5
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize,
    drbg_if.core                drbg,
    input  logic [REG_SIZE-1:0] mask
);

    localparam int CNT_W = (MIX_ROUNDS > 1) ? $clog2(MIX_ROUNDS) : 1;

    // ------------------------------------------------------------
    // round helpers
    // ------------------------------------------------------------
    function automatic logic [REG_SIZE-1:0] rotl(
        input logic [REG_SIZE-1:0] x,
        input int unsigned         n
    );
        return (x << n) | (x >> (REG_SIZE - n));
    endfunction

    // xor key, add rotated copy, xor-shift
    function automatic logic [REG_SIZE-1:0] mix_round(
        input logic [REG_SIZE-1:0] v,
        input logic [REG_SIZE-1:0] k
    );
        logic [REG_SIZE-1:0] t;
        t = v ^ k;
        t = t + rotl(t, MIX_ROT_A);
        t = t ^ (t >> MIX_ROT_B);
        return t;
    endfunction

    // one conditional subtraction into the group order
    function automatic logic [REG_SIZE-1:0] reduce(input logic [REG_SIZE-1:0] v);
        return (v >= GROUP_ORDER) ? (v - GROUP_ORDER) : v;
    endfunction

    // key and masked value
    logic [REG_SIZE-1:0] key_q;
    logic [REG_SIZE-1:0] v_masked_q;
    // mask word that v_masked_q was stored under
    logic [REG_SIZE-1:0] mask_q;

    logic [CNT_W-1:0]    round_cnt;
    logic                busy;
    logic                valid_q;
    logic [REG_SIZE-1:0] result_q;

    logic [REG_SIZE-1:0] v_plain;
    logic [REG_SIZE-1:0] v_next;
    logic                last_round;

    // unmasked only inside this cone
    assign v_plain    = v_masked_q ^ mask_q;
    assign v_next     = mix_round(v_plain, key_q);
    assign last_round = (round_cnt == CNT_W'(MIX_ROUNDS - 1));

    // ------------------------------------------------------------
    // control and state
    // ------------------------------------------------------------
    // cmd edge loads, MIX_ROUNDS round edges, then one valid cycle
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            busy       <= 1'b0;
            valid_q    <= 1'b0;
            round_cnt  <= '0;
            key_q      <= '0;
            v_masked_q <= '0;
            mask_q     <= '0;
        end
        else if (zeroize)
        begin
            busy       <= 1'b0;
            valid_q    <= 1'b0;
            round_cnt  <= '0;
            key_q      <= '0;
            v_masked_q <= '0;
            mask_q     <= '0;
        end
        else
        begin
            valid_q <= 1'b0;
            if (!busy)
            begin
                if (drbg.cmd == CMD_INIT)
                begin
                    key_q      <= drbg.entropy ^ rotl(drbg.nonce, MIX_ROT_A);
                    v_masked_q <= drbg.nonce ^ mask;
                    mask_q     <= mask;
                    round_cnt  <= '0;
                    busy       <= 1'b1;
                end
                else if (drbg.cmd == CMD_NEXT)
                begin
                    // continue from current V, fresh mask only
                    v_masked_q <= v_plain ^ mask;
                    mask_q     <= mask;
                    round_cnt  <= '0;
                    busy       <= 1'b1;
                end
            end
            else if (valid_q)
            begin
                // ready again the cycle after valid
                busy <= 1'b0;
            end
            else
            begin
                // re-mask every round
                v_masked_q <= v_next ^ mask;
                mask_q     <= mask;
                round_cnt  <= round_cnt + 1'b1;
                if (last_round)
                begin
                    valid_q <= 1'b1;
                end
            end
        end
    end

    // result register, written with the last round
    always_ff @(posedge clk)
    begin
        if (busy && !valid_q && last_round)
        begin
            result_q <= reduce(v_next);
        end
    end

    assign drbg.ready  = ~busy;
    assign drbg.valid  = valid_q;
    assign drbg.result = result_q;

endmodule

`default_nettype wire

//--- source/lfsr_mask_gen.sv
// mask word generator
`default_nettype none

module lfsr_mask_gen #(
    parameter int                  REG_SIZE       = 64,
    parameter logic [REG_SIZE-1:0] MASK_INIT_SEED = 64'h2767_f0b1_53d2_c5a3
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize,
    input  logic                reseed,
    input  logic [REG_SIZE-1:0] reseed_value,
    output logic [REG_SIZE-1:0] mask
);

    // ------------------------------------------------------------
    // feedback taps
    // ------------------------------------------------------------
    // x^16+x^15+x^13+x^4+1 pattern anchored at the top bit
    // top tap always set so a nonzero state never goes to zero
    localparam logic [REG_SIZE-1:0] TAPS =
        (REG_SIZE'(1) << (REG_SIZE - 1)) |
        (REG_SIZE'(1) << (REG_SIZE - 2)) |
        (REG_SIZE'(1) << (REG_SIZE - 4)) |
        (REG_SIZE'(1) << (REG_SIZE - 13));

    logic [REG_SIZE-1:0] lfsr_q;
    logic [REG_SIZE-1:0] lfsr_step;
    logic [REG_SIZE-1:0] lfsr_load;

    // galois step, shift right and fold taps on lsb
    assign lfsr_step = {1'b0, lfsr_q[REG_SIZE-1:1]} ^ (lfsr_q[0] ? TAPS : '0);

    // reseed mixes into current state
    // all-zero load would lock up, fall back to seed
    always_comb
    begin
        lfsr_load = reseed_value ^ lfsr_q;
        if (lfsr_load == '0)
        begin
            lfsr_load = MASK_INIT_SEED;
        end
    end

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            lfsr_q <= MASK_INIT_SEED;
        end
        else if (zeroize)
        begin
            lfsr_q <= MASK_INIT_SEED;
        end
        else if (reseed)
        begin
            lfsr_q <= lfsr_load;
        end
        else
        begin
            lfsr_q <= lfsr_step;
        end
    end

    // fresh word every cycle
    assign mask = lfsr_q;

endmodule

`default_nettype wire

//--- source/drbg_if.sv
// sequencer to generator core bus
`default_nettype none

interface drbg_if
    import ecc_rnd_cfg_pkg::*;
#(
    parameter int REG_SIZE = 64
) ();

    // one-cycle command strobe
    drbg_cmd_e             cmd;
    // sampled in the cmd cycle
    logic [REG_SIZE-1:0]   entropy;
    logic [REG_SIZE-1:0]   nonce;

    // level, low while a command runs
    logic                  ready;
    // one-cycle pulse, result valid with it
    logic                  valid;
    logic [REG_SIZE-1:0]   result;

    modport sequencer (
        output cmd,
        output entropy,
        output nonce,
        input  ready,
        input  valid,
        input  result
    );

    modport core (
        input  cmd,
        input  entropy,
        input  nonce,
        output ready,
        output valid,
        output result
    );

endinterface

`default_nettype wire

//--- source/ecc_rnd_mode_pkg.sv
// request mode and sequencer states
`default_nettype none

package ecc_rnd_mode_pkg;

    // request mode, same encoding as the engine's command field
    typedef enum logic [1:0] {
        MODE_KEYGEN = 2'b00,
        MODE_SIGN   = 2'b01,
        MODE_DH     = 2'b10
    } rnd_mode_e;

    // ------------------------------------------------------------
    // sequencer FSM
    // ------------------------------------------------------------
    typedef enum logic [3:0] {
        ST_IDLE    = 4'd0,
        // reseed value for the mask LFSR
        ST_RESEED  = 4'd1,
        ST_LAMBDA  = 4'd2,
        ST_SCALAR  = 4'd3,
        // mode decision, no command here
        ST_BRANCH  = 4'd4,
        ST_MASKING = 4'd5,
        ST_KEYGEN  = 4'd6,
        ST_SIGN    = 4'd7,
        ST_DONE    = 4'd8
    } seq_state_e;

endpackage

`default_nettype wire

//--- source/ecc_rnd_cfg_pkg.sv
// random generator core configuration
`default_nettype none

package ecc_rnd_cfg_pkg;

    // ------------------------------------------------------------
    // mixing core constants
    // ------------------------------------------------------------

    // one round per cycle
    localparam int unsigned MIX_ROUNDS = 8;

    // rotate amount of the add step
    localparam int unsigned MIX_ROT_A = 7;
    // shift amount of the xor-shift step
    localparam int unsigned MIX_ROT_B = 11;

    // commands from sequencer to core
    typedef enum logic [1:0] {
        CMD_NONE = 2'b00,
        CMD_INIT = 2'b01,
        CMD_NEXT = 2'b10
    } drbg_cmd_e;

    // default mask LFSR seed, sliced to the data width at the top
    localparam logic [383:0] DEFAULT_MASK_SEED = {
        128'h9e37_79b9_7f4a_7c15_f39c_c060_5ced_c834,
        128'h1082_276b_f3a2_7251_f86c_6a11_d0c1_8e95,
        128'h2767_f0b1_53d2_7b7f_0347_0f4d_6d4c_c5a3
    };

endpackage

`default_nettype wire
